// File: files.f
+incdir+src
src/vision_pkg.sv
src/bus_pkg.sv
src/frame_scan.sv
src/colour_classifier.sv
src/box_tracker.sv
src/msg_writer.sv
src/msg_fifo.sv
src/csr_slave.sv
src/imgproc_top.sv
tests/imgproc_chk.sv
tests/imgproc_tb.sv

// File: run.sh
#!/bin/sh
# compile with Verilator and run the testbench
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module imgproc_tb -f files.f
./obj_dir/Vimgproc_tb | awk '{ print } $0 == "all tests passed" { ok = 1 } END { exit !ok }'

// File: tests/imgproc_tb.sv
// blob detector testbench
`timescale 1ns/1ps
`default_nettype none

`include "imgproc_params.svh"

module imgproc_tb;

	localparam int img_w = 48;
	localparam int img_h = 24;
	localparam int border = 2;
	// descriptor beat plus one beat per pixel
	localparam int frame_cycles = img_w * img_h + 1;
	localparam int timeout_cycles = 10 * frame_cycles + 2000;

	// planted pixels in rgb (180,40,40) (40,100,60) (40,60,100)
	localparam vision_pkg::pixel_t red_pix = 24'hB42828;
	localparam vision_pkg::pixel_t green_pix = 24'h28643C;
	localparam vision_pkg::pixel_t blue_pix = 24'h283C64;

	logic clk;
	logic reset_n;
	logic [23:0] sink_data;
	logic sink_valid;
	logic sink_sop;
	logic sink_eop;
	logic s_chipselect;
	logic s_read;
	logic s_write;
	logic [2:0] s_address;
	logic [31:0] s_writedata;
	logic [31:0] s_readdata;

	// reference model state
	logic [31:0] rng_state = 32'd20;
	vision_pkg::box_t exp_box [3];
	logic [7:0] frames_left = 8'd0;
	logic [31:0] exp_q [$];
	// expected register reads in issue order
	logic [31:0] exp_rd [$];
	string exp_name [$];
	logic rd_seen = 1'b0;
	int cycle_cnt = 0;

	imgproc_top #(.img_w(img_w), .img_h(img_h), .border(border)) uut (
		.clk(clk), .reset_n(reset_n), .sink_data(sink_data), .sink_valid(sink_valid),
		.sink_sop(sink_sop), .sink_eop(sink_eop), .s_chipselect(s_chipselect),
		.s_read(s_read), .s_write(s_write), .s_address(s_address),
		.s_writedata(s_writedata), .s_readdata(s_readdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////
	// reference model
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// expected class of one pixel as 0 none 1 red 2 green 3 blue
	function automatic int ref_class(input vision_pkg::pixel_t p, input int x, input int y);
		int r;
		int g;
		int b;
		int hi;
		int lo;
		int d;
		int s;
		int deg;
		int h;
		r = p.red;
		g = p.green;
		b = p.blue;
		hi = (r > g) ? r : g;
		hi = (b > hi) ? b : hi;
		lo = (r < g) ? r : g;
		lo = (b < lo) ? b : lo;
		d = hi - lo;
		s = (hi == 0) ? 0 : 255 * d / hi;
		if (d == 0) begin
			deg = 0;
		end else if (hi == r) begin
			deg = ((g >= b) ? 0 : 360) * d + 60 * (g - b);
			deg = deg / d;
		end else if (hi == g) begin
			deg = (120 * d + 60 * (b - r)) / d;
		end else begin
			deg = (240 * d + 60 * (r - g)) / d;
		end
		h = deg / 2;
		// margin never classifies
		if (x <= border || x >= img_w - border || y <= border || y >= img_h - border) begin
			return 0;
		end
		if ((h > `RED_H_HI || h < `RED_H_LO) && s > `RED_S_LO && s < `RED_S_HI
			&& hi > `RED_V_LO && hi <= `RED_V_HI) begin
			return 1;
		end
		if (h > `GREEN_H_LO && h < `GREEN_H_HI && s > `GREEN_S_LO && s < `GREEN_S_HI
			&& hi > `GREEN_V_LO && hi < `GREEN_V_HI) begin
			return 2;
		end
		if (h > `BLUE_H_LO && h < `BLUE_H_HI && s > `BLUE_S_LO && s < `BLUE_S_HI
			&& hi > `BLUE_V_LO && hi < `BLUE_V_HI) begin
			return 3;
		end
		return 0;
	endfunction

	// random or grey background with known blobs at frame-dependent spots
	function automatic vision_pkg::pixel_t pick_pixel(input int f, input bit sparse,
		input int x, input int y, input logic [31:0] rnd);
		vision_pkg::pixel_t p;
		p = sparse ? {3{rnd[7:0]}} : rnd[23:0];
		if (x == 5 + f && y == 4 + f % 3) p = red_pix;
		if (x == 30 + f && y == 15) p = red_pix;
		if (!sparse) begin
			if (x == 8 + f && y == 6) p = green_pix;
			if (x == 34 && y == 12 + f % 4) p = green_pix;
			if (x == 12 && y == 9 + f) p = blue_pix;
			if (x == 40 - f && y == 19) p = blue_pix;
		end
		// strong colours on the excluded margin
		if (x == 2 && y == 10) p = red_pix;
		if (x == 46 && y == 12) p = green_pix;
		if (x == 20 && y == 22) p = blue_pix;
		if (x == 10 && y == 1) p = blue_pix;
		if (x == 25 && y == 2) p = green_pix;
		return p;
	endfunction

	// x at bit 16 and y at bit 0
	function automatic logic [31:0] corner_word(input vision_pkg::coord_t c);
		return (32'(c.x) << 16) | 32'(c.y);
	endfunction

	task automatic clear_boxes();
		int i;
		for (i = 0; i < 3; i++) begin
			exp_box[i].min.x = `COORD_W'(img_w - 1);
			exp_box[i].min.y = `COORD_W'(img_h - 1);
			exp_box[i].max = '0;
		end
	endtask

	task automatic track_pixel(input int c, input int x, input int y);
		int i;
		vision_pkg::coord_t pos;
		i = c - 1;
		pos.x = `COORD_W'(x);
		pos.y = `COORD_W'(y);
		if (c != 0) begin
			exp_box[i].min.x = (pos.x < exp_box[i].min.x) ? pos.x : exp_box[i].min.x;
			exp_box[i].min.y = (pos.y < exp_box[i].min.y) ? pos.y : exp_box[i].min.y;
			exp_box[i].max.x = (pos.x > exp_box[i].max.x) ? pos.x : exp_box[i].max.x;
			// bottom edge follows the latest row
			exp_box[i].max.y = pos.y;
		end
	endtask

	// report on interval expiry when a whole report fits
	task automatic close_frame();
		logic [23:0] tag;
		int i;
		if (frames_left == 8'd0 && exp_q.size() <= `MSG_FIFO_DEPTH - `MSG_WORDS) begin
			for (i = 0; i < 3; i++) begin
				case (i)
					0: tag = "RBB";
					1: tag = "GBB";
					default: tag = "BBB";
				endcase
				exp_q.push_back({8'h00, tag});
				exp_q.push_back(corner_word(exp_box[i].min));
				exp_q.push_back(corner_word(exp_box[i].max));
			end
			frames_left = 8'(`MSG_INTERVAL - 1);
		end else begin
			frames_left = frames_left - 8'd1;
		end
	endtask

	//////////////////////////////
	// checking
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			$display("tests failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// note each read the DUT accepts
	always @(posedge clk) begin
		rd_seen <= s_chipselect && s_read;
	end

	// read data is registered so compare half a cycle later
	always @(negedge clk) begin
		if (rd_seen) begin
			check_value(exp_name.pop_front(), s_readdata, exp_rd.pop_front());
		end
	end

	// run limit and checker failures
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (uut.u_fifo.u_chk.fail_cnt != 0) begin
			$display("a FIFO assertion failed");
			$display("tests failed");
			$fatal(1, "FIFO assertion");
		end else if (cycle_cnt == timeout_cycles) begin
			$display("timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
			$display("tests failed");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////
	// stimulus
	task automatic drive_beat(input vision_pkg::pixel_t pix, input logic sop, input logic eop);
		@(posedge clk);
		sink_data <= pix;
		sink_valid <= 1'b1;
		sink_sop <= sop;
		sink_eop <= eop;
	endtask

	task automatic drive_idle(input int n);
		repeat (n) begin
			@(posedge clk);
			sink_valid <= 1'b0;
			sink_sop <= 1'b0;
			sink_eop <= 1'b0;
		end
	endtask

	task automatic read_expect(input bus_pkg::csr_addr_e addr, input logic [31:0] exp,
		input string name);
		@(posedge clk);
		exp_rd.push_back(exp);
		exp_name.push_back(name);
		s_chipselect <= 1'b1;
		s_read <= 1'b1;
		s_address <= addr;
		@(posedge clk);
		s_chipselect <= 1'b0;
		s_read <= 1'b0;
	endtask

	task automatic write_reg(input bus_pkg::csr_addr_e addr, input logic [31:0] data);
		@(posedge clk);
		s_chipselect <= 1'b1;
		s_write <= 1'b1;
		s_address <= addr;
		s_writedata <= data;
		@(posedge clk);
		s_chipselect <= 1'b0;
		s_write <= 1'b0;
	endtask

	task automatic send_packet(input int f, input bit sparse, input bit video);
		vision_pkg::pixel_t pix;
		int x;
		int y;
		// descriptor with blue low nibble zero for video
		pix = video ? 24'h000010 : 24'h000015;
		drive_beat(pix, 1'b1, 1'b0);
		clear_boxes();
		for (y = 0; y < img_h; y++) begin
			for (x = 0; x < img_w; x++) begin
				rng_state = xorshift(rng_state);
				pix = pick_pixel(f, sparse, x, y, rng_state);
				track_pixel(ref_class(pix, x, y), x, y);
				drive_beat(pix, 1'b0, x == img_w - 1 && y == img_h - 1);
			end
		end
		if (video) begin
			close_frame();
		end
	endtask

	// status count then up to n_read words from the FIFO head
	task automatic check_report(input int n_read);
		int n;
		drive_idle(16);
		read_expect(bus_pkg::csr_status, 32'(exp_q.size()) << 8, "s_readdata status");
		n = (n_read < exp_q.size()) ? n_read : exp_q.size();
		repeat (n) begin
			read_expect(bus_pkg::csr_msg, exp_q.pop_front(), "s_readdata msg");
		end
	endtask

	initial begin
		reset_n = 1'b0;
		sink_data = '0;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		s_write = 1'b0;
		s_address = '0;
		s_writedata = '0;
		repeat (4) @(posedge clk);
		reset_n <= 1'b1;

		read_expect(bus_pkg::csr_id, `IMGPROC_ID, "s_readdata id");
		read_expect(bus_pkg::csr_status, 32'h0, "s_readdata status");

		// first frame reports and the next two are skipped
		send_packet(1, 1'b0, 1'b1);
		check_report(9);
		send_packet(2, 1'b0, 1'b1);
		check_report(9);
		send_packet(3, 1'b0, 1'b1);
		check_report(9);
		// grey frame with green and blue only on the margin
		send_packet(4, 1'b1, 1'b1);
		check_report(9);
		// non-video packet leaves the interval alone
		send_packet(5, 1'b0, 1'b0);
		check_report(9);
		send_packet(6, 1'b0, 1'b1);
		check_report(9);
		send_packet(7, 1'b0, 1'b1);
		check_report(9);
		send_packet(8, 1'b0, 1'b1);
		check_report(6);

		// flush drops the blue words
		write_reg(bus_pkg::csr_status, 32'h10);
		exp_q.delete();
		read_expect(bus_pkg::csr_status, 32'h0, "s_readdata status");
		repeat (2) @(posedge clk);

		if (exp_rd.size() == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("%0d register reads were never compared", exp_rd.size());
			$display("tests failed");
			$fatal(1, "run ended with errors");
		end
	end

endmodule

`default_nettype wire

// File: tests/imgproc_chk.sv
// message FIFO assertions
`timescale 1ns/1ps
`default_nettype none

module imgproc_chk #(
	parameter int depth = 16
) (
	input logic                         clk,
	input logic                         reset_n,
	input logic                         push,
	input logic                         pop,
	input logic [$clog2(depth + 1)-1:0] count
);

	// failures seen so far, watched by the testbench
	int fail_cnt = 0;

	// occupancy stays within the buffer
	count_in_range: assert property (@(posedge clk) disable iff (!reset_n)
		count <= depth)
		else begin
			$error("FIFO count above depth");
			fail_cnt++;
		end

	// writer checks room before a report
	no_push_when_full: assert property (@(posedge clk) disable iff (!reset_n)
		push |-> count != depth)
		else begin
			$error("push into a full FIFO");
			fail_cnt++;
		end

	no_pop_when_empty: assert property (@(posedge clk) disable iff (!reset_n)
		pop |-> count != 0)
		else begin
			$error("pop from an empty FIFO");
			fail_cnt++;
		end

endmodule

bind msg_fifo imgproc_chk #(.depth(depth)) u_chk (
	.clk(clk), .reset_n(reset_n), .push(push), .pop(pop), .count(count)
);

`default_nettype wire

// File: src/imgproc_top.sv
// colour blob detector top
`timescale 1ns/1ps
`default_nettype none

`include "imgproc_params.svh"

module imgproc_top #(
	parameter int img_w  = `IMG_W,
	parameter int img_h  = `IMG_H,
	parameter int border = `IMG_BORDER
) (
	input  logic        clk,
	input  logic        reset_n,
	// pixel stream, no back-pressure
	input  logic [23:0] sink_data,
	input  logic        sink_valid,
	input  logic        sink_sop,
	input  logic        sink_eop,
	// host register port
	input  logic        s_chipselect,
	input  logic        s_read,
	input  logic        s_write,
	input  logic  [2:0] s_address,
	input  logic [31:0] s_writedata,
	output logic [31:0] s_readdata
);

	localparam int cnt_w = $clog2(`MSG_FIFO_DEPTH + 1);

	vision_pkg::pixel_beat_t in_beat;
	vision_pkg::coord_t coord;
	logic video;
	vision_pkg::classified_t class_data;
	logic class_valid;
	vision_pkg::box_t [2:0] boxes;
	logic frame_done;
	logic push;
	logic [31:0] push_word;
	logic pop;
	logic flush;
	logic [31:0] fifo_head;
	logic [cnt_w-1:0] fifo_count;
	bus_pkg::csr_req_t req;

	assign in_beat = '{pix: sink_data, sop: sink_sop, eop: sink_eop};
	assign req = '{chipselect: s_chipselect, read: s_read, write: s_write,
		address: bus_pkg::csr_addr_e'(s_address), writedata: s_writedata};

	//////////////////////////////
	// stream path
	frame_scan #(.img_w(img_w)) u_scan (
		.clk(clk), .reset_n(reset_n), .in_beat(in_beat), .in_valid(sink_valid),
		.coord(coord), .video(video)
	);

	// classifier sees the pixel alongside its coordinate
	colour_classifier #(.img_w(img_w), .img_h(img_h), .border(border)) u_class (
		.clk(clk), .reset_n(reset_n), .in_beat(in_beat), .in_valid(sink_valid),
		.coord(coord), .video(video), .class_out(class_data), .class_valid(class_valid)
	);

	box_tracker #(.img_w(img_w), .img_h(img_h)) u_boxes (
		.clk(clk), .reset_n(reset_n), .class_in(class_data), .class_valid(class_valid),
		.boxes(boxes), .frame_done(frame_done)
	);

	//////////////////////////////
	// report path and register port
	msg_writer u_writer (
		.clk(clk), .reset_n(reset_n), .frame_done(frame_done), .boxes(boxes),
		.fifo_count(fifo_count), .push(push), .push_word(push_word)
	);

	msg_fifo #(.depth(`MSG_FIFO_DEPTH)) u_fifo (
		.clk(clk), .reset_n(reset_n), .push(push), .push_word(push_word), .pop(pop),
		.flush(flush), .head(fifo_head), .count(fifo_count)
	);

	csr_slave u_csr (
		.clk(clk), .reset_n(reset_n), .req(req), .fifo_head(fifo_head),
		.fifo_count(fifo_count), .pop(pop), .flush(flush), .s_readdata(s_readdata)
	);

endmodule

`default_nettype wire

// File: src/csr_slave.sv
// memory-mapped register port
`timescale 1ns/1ps
`default_nettype none

`include "imgproc_params.svh"

module csr_slave (
	input  logic                                    clk,
	input  logic                                    reset_n,
	input  bus_pkg::csr_req_t                       req,
	input  logic                             [31:0] fifo_head,
	input  logic [$clog2(`MSG_FIFO_DEPTH + 1)-1:0] fifo_count,
	output logic                                    pop,
	output logic                                    flush,
	output logic                             [31:0] s_readdata
);

	logic rd;
	logic wr;

	assign rd = req.chipselect && req.read;
	assign wr = req.chipselect && req.write;

	// msg read takes the head and advances on the same edge
	assign pop = rd && req.address == bus_pkg::csr_msg;
	// status bit 4 write empties the FIFO
	assign flush = wr && req.address == bus_pkg::csr_status && req.writedata[4];

	//////////////////////////////
	// read data
	// status layout
	// 15:8 words waiting in the FIFO
	// 4 flush on write
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			s_readdata <= '0;
		end else if (rd) begin
			case (req.address)
				bus_pkg::csr_status: s_readdata <= {16'h0, 8'(fifo_count), 8'h0};
				bus_pkg::csr_msg:    s_readdata <= fifo_head;
				bus_pkg::csr_id:     s_readdata <= `IMGPROC_ID;
				default:             s_readdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/msg_fifo.sv
// message FIFO
`timescale 1ns/1ps
`default_nettype none

`include "imgproc_params.svh"

module msg_fifo #(
	parameter int depth = `MSG_FIFO_DEPTH
) (
	input  logic                         clk,
	input  logic                         reset_n,
	input  logic                         push,
	input  logic                  [31:0] push_word,
	input  logic                         pop,
	input  logic                         flush,
	output logic                  [31:0] head,
	output logic [$clog2(depth + 1)-1:0] count
);

	localparam int ptr_w = $clog2(depth);

	logic [31:0] mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	// overflow and underflow requests are dropped
	assign do_push = push && count != depth;
	assign do_pop  = pop && count != 0;
	// show-ahead head word
	assign head = mem[rd_ptr];

	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
		return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_word;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// push with pop leaves count unchanged
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/msg_writer.sv
// bounding box report writer
`timescale 1ns/1ps
`default_nettype none

`include "imgproc_params.svh"

module msg_writer (
	input  logic                                    clk,
	input  logic                                    reset_n,
	input  logic                                    frame_done,
	input  vision_pkg::box_t                  [2:0] boxes,
	input  logic [$clog2(`MSG_FIFO_DEPTH + 1)-1:0] fifo_count,
	output logic                                    push,
	output logic                             [31:0] push_word
);

	// fill level that still leaves room for a whole report
	localparam int room_max = `MSG_FIFO_DEPTH - `MSG_WORDS;

	bus_pkg::msg_state_e state;
	logic [7:0] frame_cnt;
	logic start;

	// x in 26:16, y in 10:0
	function automatic logic [31:0] corner(input vision_pkg::coord_t c);
		return {{(16 - `COORD_W){1'b0}}, c.x, {(16 - `COORD_W){1'b0}}, c.y};
	endfunction

	assign start = frame_done && frame_cnt == 8'd0 && fifo_count <= room_max
		&& state == bus_pkg::msg_idle;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state     <= bus_pkg::msg_idle;
			frame_cnt <= '0;
		end else begin
			// counts down every frame, reloads only on a started report
			if (frame_done) begin
				frame_cnt <= start ? 8'(`MSG_INTERVAL - 1) : frame_cnt - 8'd1;
			end
			if (start) begin
				state <= bus_pkg::msg_red_id;
			end else if (state == bus_pkg::msg_blue_br) begin
				state <= bus_pkg::msg_idle;
			end else if (state != bus_pkg::msg_idle) begin
				state <= bus_pkg::msg_state_e'(state + 4'd1);
			end
		end
	end

	// one word per busy state
	always_comb begin
		push      = 1'b1;
		push_word = '0;
		case (state)
			bus_pkg::msg_red_id:   push_word = {8'h00, "RBB"};
			bus_pkg::msg_red_tl:   push_word = corner(boxes[0].min);
			bus_pkg::msg_red_br:   push_word = corner(boxes[0].max);
			bus_pkg::msg_green_id: push_word = {8'h00, "GBB"};
			bus_pkg::msg_green_tl: push_word = corner(boxes[1].min);
			bus_pkg::msg_green_br: push_word = corner(boxes[1].max);
			bus_pkg::msg_blue_id:  push_word = {8'h00, "BBB"};
			bus_pkg::msg_blue_tl:  push_word = corner(boxes[2].min);
			bus_pkg::msg_blue_br:  push_word = corner(boxes[2].max);
			default:               push = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: src/box_tracker.sv
// per-colour bounding boxes
`timescale 1ns/1ps
`default_nettype none

`include "imgproc_params.svh"

module box_tracker #(
	parameter int img_w = `IMG_W,
	parameter int img_h = `IMG_H
) (
	input  logic                          clk,
	input  logic                          reset_n,
	input  vision_pkg::classified_t       class_in,
	input  logic                          class_valid,
	output vision_pkg::box_t        [2:0] boxes,
	output logic                          frame_done
);

	// running boxes, index 0 red, 1 green, 2 blue
	vision_pkg::box_t [2:0] acc;
	vision_pkg::box_t [2:0] acc_next;
	vision_pkg::coord_t pos;
	logic [1:0] idx;
	logic frame_end;

	assign pos = class_in.coord;
	assign idx = class_in.colour - 2'd1;
	// last pixel of a video frame
	assign frame_end = class_valid && class_in.eop && class_in.video;

	always_comb begin
		acc_next = acc;
		if (class_in.sop) begin
			// empty box, min at far corner and max at origin
			for (int i = 0; i < 3; i++) begin
				acc_next[i].min = '{x: `COORD_W'(img_w - 1), y: `COORD_W'(img_h - 1)};
				acc_next[i].max = '0;
			end
		end else if (class_in.colour != vision_pkg::col_none) begin
			if (pos.x < acc[idx].min.x) begin
				acc_next[idx].min.x = pos.x;
			end
			if (pos.y < acc[idx].min.y) begin
				acc_next[idx].min.y = pos.y;
			end
			if (pos.x > acc[idx].max.x) begin
				acc_next[idx].max.x = pos.x;
			end
			// rows arrive in order so the latest y is the bottom
			acc_next[idx].max.y = pos.y;
		end
	end

	always_ff @(posedge clk) begin
		if (class_valid) begin
			acc <= acc_next;
		end
	end

	// latched copy includes the eop pixel itself
	always_ff @(posedge clk) begin
		if (frame_end) begin
			boxes <= acc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			frame_done <= 1'b0;
		end else begin
			frame_done <= frame_end;
		end
	end

endmodule

`default_nettype wire

// File: src/colour_classifier.sv
// hsv colour classifier
`timescale 1ns/1ps
`default_nettype none

`include "imgproc_params.svh"

module colour_classifier #(
	parameter int img_w  = `IMG_W,
	parameter int img_h  = `IMG_H,
	parameter int border = `IMG_BORDER
) (
	input  logic                    clk,
	input  logic                    reset_n,
	input  vision_pkg::pixel_beat_t in_beat,
	input  logic                    in_valid,
	input  vision_pkg::coord_t      coord,
	input  logic                    video,
	output vision_pkg::classified_t class_out,
	output logic                    class_valid
);

	logic [7:0] r;
	logic [7:0] g;
	logic [7:0] b;
	logic [7:0] v;
	logic [7:0] m;
	logic [7:0] d;
	int hue_num;
	int hue_div;
	int sat_div;
	logic [8:0] hue_deg;
	vision_pkg::hsv_t hsv;
	logic on_border;
	logic is_red;
	logic is_green;
	logic is_blue;
	vision_pkg::colour_e colour;

	assign r = in_beat.pix.red;
	assign g = in_beat.pix.green;
	assign b = in_beat.pix.blue;

	//////////////////////////////
	// rgb to hsv
	// channel max, min and spread
	assign v = (r >= g && r >= b) ? r : (g >= b) ? g : b;
	assign m = (r <= g && r <= b) ? r : (g <= b) ? g : b;
	assign d = v - m;

	always_comb begin
		// divisors forced nonzero, results masked below
		hue_div = (d == 8'd0) ? 1 : int'(d);
		sat_div = (v == 8'd0) ? 1 : int'(v);
		// numerator never negative in any sector
		hue_num = (d == 8'd0) ? 0
			: (v == r) ? ((g >= b) ? 0 : 360) * int'(d) + 60 * (int'(g) - int'(b))
			: (v == g) ? 120 * int'(d) + 60 * (int'(b) - int'(r))
			: 240 * int'(d) + 60 * (int'(r) - int'(g));
		hue_deg = 9'(hue_num / hue_div);
		// hue halved to fit a byte
		hsv.h = 8'(hue_deg >> 1);
		hsv.s = (v == 8'd0) ? 8'd0 : 8'((255 * int'(d)) / sat_div);
		hsv.v = v;
	end

	//////////////////////////////
	// threshold windows
	assign on_border = coord.x <= border || coord.x >= img_w - border
		|| coord.y <= border || coord.y >= img_h - border;

	// red hue window wraps through zero
	assign is_red = (hsv.h > `RED_H_HI || hsv.h < `RED_H_LO)
		&& hsv.s > `RED_S_LO && hsv.s < `RED_S_HI
		&& hsv.v > `RED_V_LO && hsv.v <= `RED_V_HI;
	assign is_green = hsv.h > `GREEN_H_LO && hsv.h < `GREEN_H_HI
		&& hsv.s > `GREEN_S_LO && hsv.s < `GREEN_S_HI
		&& hsv.v > `GREEN_V_LO && hsv.v < `GREEN_V_HI;
	assign is_blue = hsv.h > `BLUE_H_LO && hsv.h < `BLUE_H_HI
		&& hsv.s > `BLUE_S_LO && hsv.s < `BLUE_S_HI
		&& hsv.v > `BLUE_V_LO && hsv.v < `BLUE_V_HI;

	// descriptors and border never classify, red wins over green over blue
	assign colour = (in_beat.sop || on_border) ? vision_pkg::col_none
		: is_red ? vision_pkg::col_red
		: is_green ? vision_pkg::col_green
		: is_blue ? vision_pkg::col_blue
		: vision_pkg::col_none;

	// one register stage
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			class_valid <= 1'b0;
		end else begin
			class_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			class_out <= '{colour: colour, coord: coord, sop: in_beat.sop,
				eop: in_beat.eop, video: video};
		end
	end

endmodule

`default_nettype wire

// File: src/frame_scan.sv
// pixel coordinate counter
`timescale 1ns/1ps
`default_nettype none

`include "imgproc_params.svh"

module frame_scan #(
	parameter int img_w = `IMG_W
) (
	input  logic                    clk,
	input  logic                    reset_n,
	input  vision_pkg::pixel_beat_t in_beat,
	input  logic                    in_valid,
	output vision_pkg::coord_t      coord,
	output logic                    video
);

	// coord holds the position the next pixel will take
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			coord <= '0;
			video <= 1'b0;
		end else if (in_valid) begin
			if (in_beat.sop) begin
				// descriptor word, new packet starts at the origin
				coord <= '0;
				// blue low nibble zero marks a video packet
				video <= (in_beat.pix.blue[3:0] == 4'h0);
			end else if (coord.x == `COORD_W'(img_w - 1)) begin
				// end of line
				coord.x <= '0;
				coord.y <= coord.y + 1'b1;
			end else begin
				coord.x <= coord.x + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/bus_pkg.sv
// register port and report types
`default_nettype none

package bus_pkg;

	// register map of the slave port
	typedef enum logic [2:0] {
		csr_status = 3'd0,
		csr_msg    = 3'd1,
		csr_id     = 3'd2
	} csr_addr_e;

	// report words, three per colour
	typedef enum logic [3:0] {
		msg_idle,
		msg_red_id,
		msg_red_tl,
		msg_red_br,
		msg_green_id,
		msg_green_tl,
		msg_green_br,
		msg_blue_id,
		msg_blue_tl,
		msg_blue_br
	} msg_state_e;

	// one host access, valid for a single cycle
	typedef struct packed {
		logic        chipselect;
		logic        read;
		logic        write;
		csr_addr_e   address;
		logic [31:0] writedata;
	} csr_req_t;

endpackage

`default_nettype wire

// File: src/vision_pkg.sv
// video stream types
`default_nettype none

`include "imgproc_params.svh"

package vision_pkg;

	// one 24-bit rgb pixel, red in the top byte
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} pixel_t;

	// pixel with its packet framing
	typedef struct packed {
		pixel_t pix;
		logic   sop;
		logic   eop;
	} pixel_beat_t;

	// 8-bit hue (degrees halved), saturation and value
	typedef struct packed {
		logic [7:0] h;
		logic [7:0] s;
		logic [7:0] v;
	} hsv_t;

	typedef enum logic [1:0] {
		col_none  = 2'd0,
		col_red   = 2'd1,
		col_green = 2'd2,
		col_blue  = 2'd3
	} colour_e;

	typedef struct packed {
		logic [`COORD_W-1:0] x;
		logic [`COORD_W-1:0] y;
	} coord_t;

	// bounding box corners
	typedef struct packed {
		coord_t min;
		coord_t max;
	} box_t;

	// classifier result handed to the box tracker
	typedef struct packed {
		colour_e colour;
		coord_t  coord;
		logic    sop;
		logic    eop;
		logic    video;
	} classified_t;

endpackage

`default_nettype wire

// File: src/imgproc_params.svh
// image processor constants
`ifndef IMGPROC_PARAMS_SVH
`define IMGPROC_PARAMS_SVH

// default frame geometry and excluded margin
`define IMG_W 640
`define IMG_H 480
`define IMG_BORDER 20
`define COORD_W 11

// red hue wraps around zero
`define RED_H_HI 170
`define RED_H_LO 25
`define RED_S_LO 149
`define RED_S_HI 232
`define RED_V_LO 125
// red upper value bound is inclusive
`define RED_V_HI 200

`define GREEN_H_LO 60
`define GREEN_H_HI 80
`define GREEN_S_LO 75
`define GREEN_S_HI 200
`define GREEN_V_LO 50
`define GREEN_V_HI 128

`define BLUE_H_LO 90
`define BLUE_H_HI 120
`define BLUE_S_LO 76
`define BLUE_S_HI 195
`define BLUE_V_LO 25
`define BLUE_V_HI 128

// report cadence and message buffer
`define MSG_INTERVAL 3
`define MSG_WORDS 9
`define MSG_FIFO_DEPTH 16
`define IMGPROC_ID 32'h1234EEE2

`endif
